//--- ls_pkg.sv
package ls_pkg;

    // datapath widths
    localparam int XLEN     = 64;
    localparam int XBYTES   = XLEN / 8;
    localparam int INST_LEN = 32;
    localparam int MEMOP_W  = 3;
    localparam int MASK_W   = 8;
    localparam int REG_AW   = 5;

    // major opcodes, instr[6:2]
    localparam logic [4:0] OP_LOAD  = 5'b00000;
    localparam logic [4:0] OP_STORE = 5'b01000;
    // instr[1:0] of every 32-bit encoding
    localparam logic [1:0] OP_LSB   = 2'b11;

    // load memops, same as funct3
    localparam logic [MEMOP_W-1:0] MEMOP_LB  = 3'b000;
    localparam logic [MEMOP_W-1:0] MEMOP_LH  = 3'b001;
    localparam logic [MEMOP_W-1:0] MEMOP_LW  = 3'b010;
    localparam logic [MEMOP_W-1:0] MEMOP_LD  = 3'b011;
    localparam logic [MEMOP_W-1:0] MEMOP_LBU = 3'b100;
    localparam logic [MEMOP_W-1:0] MEMOP_LHU = 3'b101;
    localparam logic [MEMOP_W-1:0] MEMOP_LWU = 3'b110;

    // store memops, same as funct3
    localparam logic [MEMOP_W-1:0] MEMOP_SB  = 3'b000;
    localparam logic [MEMOP_W-1:0] MEMOP_SH  = 3'b001;
    localparam logic [MEMOP_W-1:0] MEMOP_SW  = 3'b010;
    localparam logic [MEMOP_W-1:0] MEMOP_SD  = 3'b011;

    // sram model geometry and timing
    localparam int SRAM_BYTES   = 256;
    localparam int SRAM_AW      = 8;
    localparam int SRAM_LATENCY = 2;
    localparam int SRAM_CNT_W   = $clog2(SRAM_LATENCY + 1);

    typedef logic [SRAM_AW-1:0]    sram_addr_t;
    typedef logic [SRAM_CNT_W-1:0] sram_cnt_t;

    // counter value at which the response fires
    localparam sram_cnt_t SRAM_CNT_LAST = sram_cnt_t'(SRAM_LATENCY);

    // decoded request, ls_ctr to lsu
    typedef struct packed {
        logic               valid;
        logic               rden;
        logic               wren;
        logic [MEMOP_W-1:0] memop;
        logic [XLEN-1:0]    addr;
        logic [XLEN-1:0]    wdata;
    } ls_req_t;

    // lsu to sram
    typedef struct packed {
        logic [XLEN-1:0]   addr;
        logic              rd_en;
        logic              wr_en;
        logic [XLEN-1:0]   wr_data;
        // byte count 1/2/4/8, not per-byte enables
        logic [MASK_W-1:0] wr_mask;
    } sram_req_t;

    // sram back to lsu
    typedef struct packed {
        logic            rd_data_valid;
        logic            wr_data_ok;
        logic [XLEN-1:0] rd_data;
    } sram_rsp_t;

    // retired instruction record
    typedef struct packed {
        logic              valid;
        logic              is_load;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } wb_t;

endpackage

//--- ls_ctr.sv
`timescale 1ns/1ps

module ls_ctr (
    input  logic [ls_pkg::INST_LEN-1:0] instr_i,
    input  logic                        valid_i,
    input  logic [ls_pkg::XLEN-1:0]     addr_i,
    input  logic [ls_pkg::XLEN-1:0]     rs2_i,
    input  ls_pkg::wb_t                 wb_i,
    output ls_pkg::ls_req_t             req_o
);

    logic                          is_load;
    logic                          is_store;
    logic                          fwd_hit;
    logic [ls_pkg::REG_AW-1:0]     rs2_idx;
    logic [ls_pkg::XLEN-1:0]       st_data;

    // loads need the full 7-bit opcode
    assign is_load  = valid_i &&
                      (instr_i[6:0] == {ls_pkg::OP_LOAD, ls_pkg::OP_LSB});
    // stores only look at the major opcode
    assign is_store = valid_i && (instr_i[6:2] == ls_pkg::OP_STORE);

    // rs2 field of an S-type encoding
    assign rs2_idx = instr_i[24:20];

    // last retire was a load into our rs2, so rs2_i is stale
    // x0 never carries a loaded value
    assign fwd_hit = is_store &&
                     wb_i.is_load &&
                     (wb_i.rd != '0) &&
                     (rs2_idx == wb_i.rd);

    // loaded value replaces register operand
    assign st_data = fwd_hit ? wb_i.data : rs2_i;

    always_comb begin
        req_o.valid = valid_i;
        req_o.rden  = is_load;
        req_o.wren  = is_store;
        // funct3 picks size and sign, zero when idle
        req_o.memop = valid_i ? instr_i[14:12] : '0;
        // address from execute, already aligned
        req_o.addr  = addr_i;
        req_o.wdata = st_data;
    end

endmodule

//--- lsu.sv
`timescale 1ns/1ps

module lsu (
    input  ls_pkg::ls_req_t          req_i,
    input  ls_pkg::sram_rsp_t        rsp_i,
    output ls_pkg::sram_req_t        sram_o,
    output logic [ls_pkg::XLEN-1:0]  ls_res_o,
    output logic                     ls_not_ok_o,
    output logic                     ls_done_o
);

    logic [ls_pkg::XLEN-1:0]   rd_data;
    logic [ls_pkg::MASK_W-1:0] wr_mask;
    logic                      rd_wait;
    logic                      wr_wait;
    logic                      stall;

    // request goes straight to the sram
    always_comb begin
        sram_o.addr    = req_i.addr;
        sram_o.rd_en   = req_i.rden;
        sram_o.wr_en   = req_i.wren;
        sram_o.wr_data = req_i.wdata;
        sram_o.wr_mask = wr_mask;
    end

    // addressed byte sits at bit 0
    assign rd_data = rsp_i.rd_data;

    // store size as a byte count
    always_comb begin
        wr_mask = '0;
        if (req_i.wren) begin
            case (req_i.memop)
                ls_pkg::MEMOP_SB: wr_mask = 8'd1;
                ls_pkg::MEMOP_SH: wr_mask = 8'd2;
                ls_pkg::MEMOP_SW: wr_mask = 8'd4;
                ls_pkg::MEMOP_SD: wr_mask = 8'd8;
                default:          wr_mask = '0;
            endcase
        end
    end

    // load extension
    always_comb begin
        ls_res_o = '0;
        if (req_i.rden) begin
            case (req_i.memop)
                ls_pkg::MEMOP_LB: begin
                    ls_res_o = {{(ls_pkg::XLEN-8){rd_data[7]}}, rd_data[7:0]};
                end
                ls_pkg::MEMOP_LBU: begin
                    ls_res_o = {{(ls_pkg::XLEN-8){1'b0}}, rd_data[7:0]};
                end
                ls_pkg::MEMOP_LH: begin
                    ls_res_o = {{(ls_pkg::XLEN-16){rd_data[15]}}, rd_data[15:0]};
                end
                ls_pkg::MEMOP_LHU: begin
                    ls_res_o = {{(ls_pkg::XLEN-16){1'b0}}, rd_data[15:0]};
                end
                ls_pkg::MEMOP_LW: begin
                    ls_res_o = {{(ls_pkg::XLEN-32){rd_data[31]}}, rd_data[31:0]};
                end
                ls_pkg::MEMOP_LWU: begin
                    ls_res_o = {{(ls_pkg::XLEN-32){1'b0}}, rd_data[31:0]};
                end
                ls_pkg::MEMOP_LD: begin
                    ls_res_o = rd_data;
                end
                // funct3 111 is not a load
                default: begin
                    ls_res_o = '0;
                end
            endcase
        end
    end

    // waiting on the sram latency counter
    assign rd_wait = req_i.rden && !rsp_i.rd_data_valid;
    assign wr_wait = req_i.wren && !rsp_i.wr_data_ok;
    assign stall   = rd_wait || wr_wait;

    assign ls_not_ok_o = stall;
    // non-memory instructions pass in one cycle
    assign ls_done_o   = req_i.valid && !stall;

endmodule

//--- data_sram.sv
`timescale 1ns/1ps

module data_sram (
    input  logic              clk,
    input  logic              rst_i,
    input  ls_pkg::sram_req_t req_i,
    output ls_pkg::sram_rsp_t rsp_o
);

    // byte storage
    logic [7:0]              mem [ls_pkg::SRAM_BYTES];
    ls_pkg::sram_cnt_t       wait_cnt;
    ls_pkg::sram_addr_t      base;
    logic                    resp_due;
    logic                    rd_ok;
    logic                    wr_ok;
    logic [ls_pkg::XLEN-1:0] rd_word;

    // only the low address bits reach the array
    assign base = req_i.addr[ls_pkg::SRAM_AW-1:0];

    // latency counter
    // counts up while an access is held, clears after the response cycle
    assign resp_due = (wait_cnt == ls_pkg::SRAM_CNT_LAST);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            wait_cnt <= '0;
        end else if (resp_due) begin
            wait_cnt <= '0;
        end else if (req_i.rd_en || req_i.wr_en) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    // responses fire in the last held cycle
    assign rd_ok = req_i.rd_en && resp_due;
    assign wr_ok = req_i.wr_en && resp_due;

    // eight bytes from base, wraps at the top of the array
    always_comb begin
        for (int i = 0; i < ls_pkg::XBYTES; i++) begin
            rd_word[8*i +: 8] = mem[base + ls_pkg::sram_addr_t'(i)];
        end
    end

    // write wr_mask bytes starting at base
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            for (int i = 0; i < ls_pkg::XBYTES; i++) begin
                if (i < int'(req_i.wr_mask)) begin
                    mem[base + ls_pkg::sram_addr_t'(i)] <= req_i.wr_data[8*i +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp_o.rd_data_valid = rd_ok;
        rsp_o.wr_data_ok    = wr_ok;
        // data always visible, lsu qualifies it
        rsp_o.rd_data       = rd_word;
    end

endmodule

//--- mem_wb_reg.sv
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        ls_done_i,
    input  logic [ls_pkg::INST_LEN-1:0] instr_i,
    input  logic [ls_pkg::XLEN-1:0]     ls_res_i,
    output ls_pkg::wb_t                 wb_o
);

    logic                      is_load;
    logic                      valid_q;
    logic                      is_load_q;
    logic [ls_pkg::REG_AW-1:0] rd_q;
    logic [ls_pkg::XLEN-1:0]   data_q;

    assign is_load = (instr_i[6:0] == {ls_pkg::OP_LOAD, ls_pkg::OP_LSB});

    // valid is a one-cycle pulse per retire
    // is_load holds until the next retire, used for forwarding
    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q   <= 1'b0;
            is_load_q <= 1'b0;
        end else begin
            valid_q <= ls_done_i;
            if (ls_done_i) begin
                is_load_q <= is_load;
            end
        end
    end

    // destination and result
    always_ff @(posedge clk) begin
        if (ls_done_i) begin
            rd_q   <= instr_i[11:7];
            // stores and alu ops carry no memory result
            data_q <= is_load ? ls_res_i : '0;
        end
    end

    always_comb begin
        wb_o.valid   = valid_q;
        wb_o.is_load = is_load_q;
        wb_o.rd      = rd_q;
        wb_o.data    = data_q;
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                        clk,
    input  logic                        rst_i,
    input  logic                        valid_i,
    input  logic [ls_pkg::INST_LEN-1:0] instr_i,
    input  logic [ls_pkg::XLEN-1:0]     rs2_i,
    input  logic [ls_pkg::XLEN-1:0]     addr_i,
    output logic [ls_pkg::XLEN-1:0]     ls_res_o,
    output logic                        ls_not_ok_o,
    output ls_pkg::wb_t                 wb_o
);

    ls_pkg::ls_req_t   ls_req;
    ls_pkg::sram_req_t sram_req;
    ls_pkg::sram_rsp_t sram_rsp;
    // retire strobe
    logic              ls_done;

    // decode plus store data forwarding from wb_o
    ls_ctr ls_ctr_inst (
        .instr_i (instr_i),
        .valid_i (valid_i),
        .addr_i  (addr_i),
        .rs2_i   (rs2_i),
        .wb_i    (wb_o),
        .req_o   (ls_req)
    );

    // combinational load-store unit
    lsu lsu_inst (
        .req_i       (ls_req),
        .rsp_i       (sram_rsp),
        .sram_o      (sram_req),
        .ls_res_o    (ls_res_o),
        .ls_not_ok_o (ls_not_ok_o),
        .ls_done_o   (ls_done)
    );

    // fixed-latency memory model
    data_sram data_sram_inst (
        .clk   (clk),
        .rst_i (rst_i),
        .req_i (sram_req),
        .rsp_o (sram_rsp)
    );

    // retire record, also feeds ls_ctr
    mem_wb_reg mem_wb_reg_inst (
        .clk       (clk),
        .rst_i     (rst_i),
        .ls_done_i (ls_done),
        .instr_i   (instr_i),
        .ls_res_i  (ls_res_o),
        .wb_o      (wb_o)
    );

endmodule

//--- mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb;

    // about 80 instructions at 5 cycles each, plus reset, with wide margin
    localparam int TIMEOUT_CYCLES = 2000;
    // bits 7, 15, 31 and 63, the sign bits of every load size
    localparam logic [63:0] SIGN_BITS = 64'h8000_0000_8000_8080;

    logic                        clk;
    logic                        rst_i;
    logic                        valid_i;
    logic [ls_pkg::INST_LEN-1:0] instr_i;
    logic [ls_pkg::XLEN-1:0]     rs2_i;
    logic [ls_pkg::XLEN-1:0]     addr_i;
    logic [ls_pkg::XLEN-1:0]     ls_res_o;
    logic                        ls_not_ok_o;
    ls_pkg::wb_t                 wb_o;

    // expected memory contents
    logic [7:0]  ref_mem [256];
    logic [15:0] lfsr_state;
    int          cycle_cnt = 0;

    mem_stage mem_stage_inst (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .rs2_i       (rs2_i),
        .addr_i      (addr_i),
        .ls_res_o    (ls_res_o),
        .ls_not_ok_o (ls_not_ok_o),
        .wb_o        (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit
    task automatic take_random(input int nbits, output logic [63:0] val);
        val = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[62:0], lfsr_state[0]};
        end
    endtask

    // rs1 = x1, imm = 0
    function automatic logic [31:0] encode_load(input logic [2:0] f3, input logic [4:0] rd);
        return {12'd0, 5'd1, f3, rd, 7'b0000011};
    endfunction

    // imm = 0, so the rd slot reads as x0
    function automatic logic [31:0] encode_store(input logic [2:0] f3, input logic [4:0] rs2);
        return {7'd0, rs2, 5'd1, f3, 5'd0, 7'b0100011};
    endfunction

    // addi rd, x1, 5
    function automatic logic [31:0] encode_addi(input logic [4:0] rd);
        return {12'd5, 5'd1, 3'b000, rd, 7'b0010011};
    endfunction

    // size from funct3 of a store
    function automatic int store_bytes(input logic [2:0] f3);
        case (f3)
            3'b000:  return 1;
            3'b001:  return 2;
            3'b010:  return 4;
            default: return 8;
        endcase
    endfunction

    // read eight bytes from the model, then extend by funct3
    function automatic logic [63:0] predict_load(input logic [2:0] f3, input logic [63:0] addr);
        logic [63:0] raw;
        logic [7:0]  a;
        a = addr[7:0];
        for (int i = 0; i < 8; i++) begin
            raw[8*i +: 8] = ref_mem[8'(a + 8'(i))];
        end
        case (f3)
            3'b000:  return {{56{raw[7]}}, raw[7:0]};
            3'b001:  return {{48{raw[15]}}, raw[15:0]};
            3'b010:  return {{32{raw[31]}}, raw[31:0]};
            3'b100:  return {56'd0, raw[7:0]};
            3'b101:  return {48'd0, raw[15:0]};
            3'b110:  return {32'd0, raw[31:0]};
            default: return raw;
        endcase
    endfunction

    // drive one instruction, hold through the stall, check result and writeback
    task automatic run_instr(input logic [31:0] instr, input logic [63:0] rs2,
                             input logic [63:0] addr, input bit is_mem,
                             input bit is_load, input logic [63:0] exp_res);
        int          stalls;
        bit          done;
        logic [63:0] res;
        stalls = 0;
        done   = 1'b0;
        @(posedge clk);
        #1;
        valid_i = 1'b1;
        instr_i = instr;
        rs2_i   = rs2;
        addr_i  = addr;
        // sample mid-cycle, inputs are stable by then
        while (!done) begin
            @(negedge clk);
            // nothing retires before the response cycle
            check_value("wb_o.valid", wb_o.valid, 0);
            if (ls_not_ok_o) begin
                stalls++;
                @(posedge clk);
                #1;
            end else begin
                done = 1'b1;
                res  = ls_res_o;
            end
        end
        check_value("stall cycles", stalls, is_mem ? ls_pkg::SRAM_LATENCY : 0);
        if (is_load) begin
            check_value("ls_res_o", res, exp_res);
        end
        // retire edge
        @(posedge clk);
        #1;
        valid_i = 1'b0;
        instr_i = '0;
        rs2_i   = '0;
        addr_i  = '0;
        @(negedge clk);
        check_value("wb_o.valid", wb_o.valid, 1);
        check_value("wb_o.is_load", wb_o.is_load, is_load);
        check_value("wb_o.rd", wb_o.rd, instr[11:7]);
        check_value("wb_o.data", wb_o.data, is_load ? exp_res : 64'd0);
        // idle cycle, nothing retires
        @(negedge clk);
        check_value("wb_o.valid", wb_o.valid, 0);
        check_value("ls_not_ok_o", ls_not_ok_o, 0);
    endtask

    // stored is what memory should receive, which differs from rs2_val when forwarding
    task automatic do_store(input logic [2:0] f3, input logic [4:0] rs2_idx,
                            input logic [63:0] rs2_val, input logic [63:0] addr,
                            input logic [63:0] stored);
        run_instr(encode_store(f3, rs2_idx), rs2_val, addr, 1'b1, 1'b0, 64'd0);
        for (int i = 0; i < store_bytes(f3); i++) begin
            ref_mem[8'(addr[7:0] + 8'(i))] = stored[8*i +: 8];
        end
    endtask

    task automatic do_load(input logic [2:0] f3, input logic [4:0] rd, input logic [63:0] addr);
        run_instr(encode_load(f3, rd), 64'hdead_beef_dead_beef, addr, 1'b1, 1'b1,
                  predict_load(f3, addr));
    endtask

    // every doubleword gets random data so no read sees X
    task automatic fill_memory();
        logic [63:0] d;
        for (int a = 0; a < 256; a += 8) begin
            take_random(64, d);
            do_store(ls_pkg::MEMOP_SD, 5'd2, d, 64'(a), d);
        end
    endtask

    task automatic test_store_sizes();
        logic [2:0]  sizes [4];
        logic [63:0] a;
        logic [63:0] d;
        sizes = '{ls_pkg::MEMOP_SD, ls_pkg::MEMOP_SW, ls_pkg::MEMOP_SH, ls_pkg::MEMOP_SB};
        for (int r = 0; r < 2; r++) begin
            foreach (sizes[k]) begin
                take_random(8, a);
                a = a & ~64'(store_bytes(sizes[k]) - 1);
                take_random(64, d);
                do_store(sizes[k], 5'd2, d, a, d);
                // whole doubleword shows exactly which bytes changed
                do_load(ls_pkg::MEMOP_LD, 5'd10, a & ~64'd7);
            end
        end
    endtask

    task automatic test_load_extension();
        logic [2:0]  ops [7];
        logic [63:0] a;
        logic [63:0] d;
        ops = '{ls_pkg::MEMOP_LB, ls_pkg::MEMOP_LH, ls_pkg::MEMOP_LW, ls_pkg::MEMOP_LD,
                ls_pkg::MEMOP_LBU, ls_pkg::MEMOP_LHU, ls_pkg::MEMOP_LWU};
        // first pass negative values, second pass positive
        for (int p = 0; p < 2; p++) begin
            take_random(5, a);
            a = a << 3;
            take_random(64, d);
            d = (p == 0) ? (d | SIGN_BITS) : (d & ~SIGN_BITS);
            do_store(ls_pkg::MEMOP_SD, 5'd2, d, a, d);
            foreach (ops[k]) begin
                do_load(ops[k], 5'd11, a);
            end
        end
    endtask

    task automatic test_stall_and_idle();
        logic [63:0] r;
        for (int i = 0; i < 3; i++) begin
            take_random(64, r);
            run_instr(encode_addi(5'd3), r, r, 1'b0, 1'b0, 64'd0);
        end
        // valid low, opcode of a store on the bus
        @(posedge clk);
        #1;
        instr_i = encode_store(ls_pkg::MEMOP_SD, 5'd2);
        repeat (4) begin
            @(negedge clk);
            check_value("wb_o.valid", wb_o.valid, 0);
            check_value("ls_not_ok_o", ls_not_ok_o, 0);
        end
        @(posedge clk);
        #1;
        instr_i = '0;
    endtask

    task automatic test_forwarding();
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] v;
        logic [63:0] r;
        take_random(5, a);
        a = a << 3;
        b = a ^ 64'd8;
        v = predict_load(ls_pkg::MEMOP_LD, a);
        do_load(ls_pkg::MEMOP_LD, 5'd5, a);
        // rs2_i is stale, the x5 load value must be written
        do_store(ls_pkg::MEMOP_SD, 5'd5, ~v, b, v);
        do_load(ls_pkg::MEMOP_LD, 5'd7, b);
        // rs2 = x6 does not match x7, rs2_i used as is
        take_random(64, r);
        do_store(ls_pkg::MEMOP_SD, 5'd6, r, b, r);
        do_load(ls_pkg::MEMOP_LD, 5'd7, b);
    endtask

    initial begin
        rst_i      = 1'b1;
        valid_i    = 1'b0;
        instr_i    = '0;
        rs2_i      = '0;
        addr_i     = '0;
        lfsr_state = 16'd16;
        repeat (4) @(posedge clk);
        #1;
        rst_i = 1'b0;
        @(negedge clk);
        check_value("wb_o.valid", wb_o.valid, 0);
        check_value("ls_not_ok_o", ls_not_ok_o, 0);
        fill_memory();
        test_store_sizes();
        test_load_extension();
        test_stall_and_idle();
        test_forwarding();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verilog.f
ls_pkg.sv
ls_ctr.sv
lsu.sv
data_sram.sv
mem_wb_reg.sv
mem_stage.sv
mem_stage_tb.sv

//--- run.sh
#!/bin/sh
# build the mem_stage testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f verilog.f \
    --top-module mem_stage_tb -o mem_stage_sim || exit 1

out=$(./obj_dir/mem_stage_sim 2>&1)
echo "$out"

# the run passes only if the pass line was printed
echo "$out" | grep -qx "PASS: all tests" && exit 0 || exit 1
